//--- fifo_defines.svh
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// --------------------------------------------------
// FIFO build options
// --------------------------------------------------

// Width of one stored word
`define FIFO_DATA_W 8

// Memory address width
// Depth is two to the power of this
`define FIFO_ADDR_W 4

// Read output form
// 1 gives first-word-fall-through, 0 gives a registered dout
`define FIFO_FWFT 0

`endif

//--- fifo_ptr_pkg.sv
package fifo_ptr_pkg;

	`include "fifo_defines.svh"

	// --------------------------------------------------
	// Pointer and address types
	// --------------------------------------------------

	// Memory address, wrap bit excluded
	typedef logic [`FIFO_ADDR_W-1:0] addr_t;

	// Binary pointer with extra wrap bit on top
	typedef logic [`FIFO_ADDR_W:0] ptr_bin_t;

	// Gray form of the same pointer, crosses clock domains
	typedef logic [`FIFO_ADDR_W:0] ptr_gray_t;

	// Binary to Gray conversion
	// Only one bit flips per increment
	function automatic ptr_gray_t bin2gray(input ptr_bin_t bin);
		return ptr_gray_t'(bin ^ (bin >> 1));
	endfunction

endpackage

//--- fifo_data_pkg.sv
package fifo_data_pkg;

	`include "fifo_defines.svh"

	// --------------------------------------------------
	// Payload types
	// --------------------------------------------------

	// One FIFO word, as written and as read
	typedef logic [`FIFO_DATA_W-1:0] data_t;

endpackage

//--- fifo_mem_if.sv
`timescale 1ns/1ns

// --------------------------------------------------
// Storage access bundle
// --------------------------------------------------
interface fifo_mem_if;

	// Write port, wr_clk domain
	logic                 we;
	fifo_ptr_pkg::addr_t  waddr;
	fifo_data_pkg::data_t wdata;

	// Read port, address from rd_clk domain
	fifo_ptr_pkg::addr_t  raddr;
	fifo_data_pkg::data_t rdata;

	// Write controller side
	modport writer (
		output we,
		output waddr,
		output wdata
	);

	// Read controller side
	// rdata comes back without a clock
	modport reader (
		output raddr,
		input  rdata
	);

	// Storage array side
	modport memory (
		input  we,
		input  waddr,
		input  wdata,
		input  raddr,
		output rdata
	);

endinterface

//--- fifo_dual_port_ram.sv
`timescale 1ns/1ns

module fifo_dual_port_ram (
	input logic      wr_clk,
	fifo_mem_if.memory mem
);

	`include "fifo_defines.svh"

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------

	// Number of words held
	localparam int DEPTH = 1 << `FIFO_ADDR_W;

	// Word array
	fifo_data_pkg::data_t ram [DEPTH];

	// --------------------------------------------------
	// Write side
	// --------------------------------------------------

	// Word stored on the wr_clk edge with we high
	always_ff @(posedge wr_clk)
	begin
		if (mem.we)
		begin
			ram[mem.waddr] <= mem.wdata;
		end
	end

	// --------------------------------------------------
	// Read side
	// --------------------------------------------------

	// Plain lookup, follows raddr directly
	assign mem.rdata = ram[mem.raddr];

endmodule

//--- fifo_ptr_sync.sv
`timescale 1ns/1ns

module fifo_ptr_sync (
	input  logic                  clk,
	input  logic                  rst,
	input  fifo_ptr_pkg::ptr_gray_t ptr_in,
	output fifo_ptr_pkg::ptr_gray_t ptr_out
);

	// --------------------------------------------------
	// Two-flop synchronizer
	// --------------------------------------------------

	// First stage may go metastable
	// Gray input means at most one bit is uncertain
	(* ASYNC_REG = "TRUE" *) fifo_ptr_pkg::ptr_gray_t stage1;
	(* ASYNC_REG = "TRUE" *) fifo_ptr_pkg::ptr_gray_t stage2;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			stage1 <= '0;
			stage2 <= '0;
		end
		else
		begin
			// Shift one step per clk edge
			stage1 <= ptr_in;
			stage2 <= stage1;
		end
	end

	// Settled copy, two clk cycles late
	assign ptr_out = stage2;

endmodule

//--- fifo_wr_ctrl.sv
`timescale 1ns/1ns

module fifo_wr_ctrl (
	input  logic                    wr_clk,
	input  logic                    wr_rst,
	input  logic                    wr_en,
	input  fifo_data_pkg::data_t    din,
	input  fifo_ptr_pkg::ptr_gray_t rptr_sync,
	output fifo_ptr_pkg::ptr_gray_t wptr_gray,
	output logic                    full,
	fifo_mem_if.writer              mem
);

	`include "fifo_defines.svh"

	// Top index of a pointer, the wrap bit
	localparam int MSB = `FIFO_ADDR_W;

	// Binary write pointer
	fifo_ptr_pkg::ptr_bin_t  wbin;
	// Pointer values after this edge
	fifo_ptr_pkg::ptr_bin_t  wbin_next;
	fifo_ptr_pkg::ptr_gray_t wgray_next;
	// Read pointer as seen when the FIFO is full
	fifo_ptr_pkg::ptr_gray_t rptr_full;
	logic                    wr_accept;

	// --------------------------------------------------
	// Write acceptance
	// --------------------------------------------------

	// Writes while full are dropped
	assign wr_accept  = wr_en & ~full;
	assign wbin_next  = wbin + fifo_ptr_pkg::ptr_bin_t'(wr_accept);
	assign wgray_next = fifo_ptr_pkg::bin2gray(wbin_next);

	// Memory write port
	assign mem.we    = wr_accept;
	assign mem.waddr = wbin[MSB-1:0];
	assign mem.wdata = din;

	// --------------------------------------------------
	// Pointer registers
	// --------------------------------------------------

	always_ff @(posedge wr_clk or posedge wr_rst)
	begin
		if (wr_rst)
		begin
			wbin      <= '0;
			wptr_gray <= '0;
		end
		else
		begin
			wbin      <= wbin_next;
			wptr_gray <= wgray_next;
		end
	end

	// --------------------------------------------------
	// Full flag
	// --------------------------------------------------

	// One lap ahead in Gray code means top two bits differ
	assign rptr_full = {~rptr_sync[MSB:MSB-1], rptr_sync[MSB-2:0]};

	// Rises on the write that takes the last slot
	always_ff @(posedge wr_clk or posedge wr_rst)
	begin
		if (wr_rst)
		begin
			full <= 1'b0;
		end
		else
		begin
			full <= (wgray_next == rptr_full);
		end
	end

endmodule

//--- fifo_rd_ctrl.sv
`timescale 1ns/1ns

module fifo_rd_ctrl (
	input  logic                    rd_clk,
	input  logic                    rd_rst,
	input  logic                    rd_en,
	input  fifo_ptr_pkg::ptr_gray_t wptr_sync,
	output fifo_ptr_pkg::ptr_gray_t rptr_gray,
	output logic                    empty,
	output fifo_data_pkg::data_t    dout,
	fifo_mem_if.reader              mem
);

	`include "fifo_defines.svh"

	// Binary read pointer
	fifo_ptr_pkg::ptr_bin_t  rbin;
	// Pointer values after this edge
	fifo_ptr_pkg::ptr_bin_t  rbin_next;
	fifo_ptr_pkg::ptr_gray_t rgray_next;
	logic                    rd_accept;

	// --------------------------------------------------
	// Read acceptance
	// --------------------------------------------------

	// Reads while empty are dropped
	assign rd_accept  = rd_en & ~empty;
	assign rbin_next  = rbin + fifo_ptr_pkg::ptr_bin_t'(rd_accept);
	assign rgray_next = fifo_ptr_pkg::bin2gray(rbin_next);

	// Head word address, wrap bit dropped
	assign mem.raddr = rbin[`FIFO_ADDR_W-1:0];

	// --------------------------------------------------
	// Pointer registers
	// --------------------------------------------------

	always_ff @(posedge rd_clk or posedge rd_rst)
	begin
		if (rd_rst)
		begin
			rbin      <= '0;
			rptr_gray <= '0;
		end
		else
		begin
			rbin      <= rbin_next;
			rptr_gray <= rgray_next;
		end
	end

	// --------------------------------------------------
	// Empty flag
	// --------------------------------------------------

	// Caught up with the write pointer
	// Set at reset so nothing is read before data lands
	always_ff @(posedge rd_clk or posedge rd_rst)
	begin
		if (rd_rst)
		begin
			empty <= 1'b1;
		end
		else
		begin
			empty <= (rgray_next == wptr_sync);
		end
	end

	// --------------------------------------------------
	// Output data stage
	// --------------------------------------------------

	generate
		if (`FIFO_FWFT != 0)
		begin : g_fwft
			// Head word shown as soon as it is there
			// Only meaningful while empty is low
			assign dout = mem.rdata;
		end
		else
		begin : g_reg
			// Head word captured on the accepting edge
			// Holds while no read is accepted
			always_ff @(posedge rd_clk or posedge rd_rst)
			begin
				if (rd_rst)
				begin
					dout <= '0;
				end
				else if (rd_accept)
				begin
					dout <= mem.rdata;
				end
			end
		end
	endgenerate

endmodule

//--- fifo_async.sv
`timescale 1ns/1ns

module fifo_async (
	// Write domain
	input  fifo_data_pkg::data_t din,
	input  logic                 wr_en,
	input  logic                 wr_clk,
	input  logic                 wr_rst,
	output logic                 full,
	// Read domain
	input  logic                 rd_en,
	input  logic                 rd_clk,
	input  logic                 rd_rst,
	output logic                 empty,
	output fifo_data_pkg::data_t dout
);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------

	// Gray pointers in their own domain
	fifo_ptr_pkg::ptr_gray_t wptr_gray;
	fifo_ptr_pkg::ptr_gray_t rptr_gray;

	// Gray pointers after crossing
	// wptr_sync lives in rd_clk, rptr_sync in wr_clk
	fifo_ptr_pkg::ptr_gray_t wptr_sync;
	fifo_ptr_pkg::ptr_gray_t rptr_sync;

	// Storage ports shared by both controllers
	fifo_mem_if mem_bus ();

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------

	fifo_dual_port_ram u_ram (
		.wr_clk (wr_clk),
		.mem    (mem_bus.memory)
	);

	// --------------------------------------------------
	// Write domain
	// --------------------------------------------------

	fifo_wr_ctrl u_wr_ctrl (
		.wr_clk    (wr_clk),
		.wr_rst    (wr_rst),
		.wr_en     (wr_en),
		.din       (din),
		.rptr_sync (rptr_sync),
		.wptr_gray (wptr_gray),
		.full      (full),
		.mem       (mem_bus.writer)
	);

	// Read pointer into wr_clk
	fifo_ptr_sync u_sync_r2w (
		.clk     (wr_clk),
		.rst     (wr_rst),
		.ptr_in  (rptr_gray),
		.ptr_out (rptr_sync)
	);

	// --------------------------------------------------
	// Read domain
	// --------------------------------------------------

	fifo_rd_ctrl u_rd_ctrl (
		.rd_clk    (rd_clk),
		.rd_rst    (rd_rst),
		.rd_en     (rd_en),
		.wptr_sync (wptr_sync),
		.rptr_gray (rptr_gray),
		.empty     (empty),
		.dout      (dout),
		.mem       (mem_bus.reader)
	);

	// Write pointer into rd_clk
	fifo_ptr_sync u_sync_w2r (
		.clk     (rd_clk),
		.rst     (rd_rst),
		.ptr_in  (wptr_gray),
		.ptr_out (wptr_sync)
	);

endmodule

//--- fifo_async_asserts.sv
`timescale 1ns/1ns

module fifo_async_asserts (
	input logic                    wr_clk,
	input logic                    wr_rst,
	input logic                    wr_en,
	input logic                    full,
	input logic                    rd_clk,
	input logic                    rd_rst,
	input logic                    empty,
	input fifo_ptr_pkg::ptr_gray_t wptr_gray,
	input fifo_ptr_pkg::ptr_gray_t rptr_gray
);

	// Running total of failed assertions
	int fail_count = 0;

	// --------------------------------------------------
	// Gray pointer steps
	// --------------------------------------------------

	// Write pointer moves by one Gray step at most
	a_wptr_one_bit : assert property (@(posedge wr_clk) disable iff (wr_rst)
		$countones(wptr_gray ^ $past(wptr_gray)) <= 1)
		else
		begin
			$error("write Gray pointer changed more than one bit");
			fail_count++;
		end

	// Same rule on the read side
	a_rptr_one_bit : assert property (@(posedge rd_clk) disable iff (rd_rst)
		$countones(rptr_gray ^ $past(rptr_gray)) <= 1)
		else
		begin
			$error("read Gray pointer changed more than one bit");
			fail_count++;
		end

	// --------------------------------------------------
	// Back-pressure
	// --------------------------------------------------

	// Blocked write leaves the pointer alone
	a_wptr_hold_full : assert property (@(posedge wr_clk) disable iff (wr_rst)
		(full && wr_en) |=> $stable(wptr_gray))
		else
		begin
			$error("write pointer moved while full");
			fail_count++;
		end

	// Nothing to read, pointer stays
	a_rptr_hold_empty : assert property (@(posedge rd_clk) disable iff (rd_rst)
		empty |=> $stable(rptr_gray))
		else
		begin
			$error("read pointer moved while empty");
			fail_count++;
		end

	// Both flags at once would mean a broken pointer compare
	a_not_full_and_empty : assert property (@(posedge rd_clk) disable iff (wr_rst || rd_rst)
		!(full && empty))
		else
		begin
			$error("full and empty high together");
			fail_count++;
		end

endmodule

bind fifo_async fifo_async_asserts u_asserts (
	.wr_clk    (wr_clk),
	.wr_rst    (wr_rst),
	.wr_en     (wr_en),
	.full      (full),
	.rd_clk    (rd_clk),
	.rd_rst    (rd_rst),
	.empty     (empty),
	.wptr_gray (wptr_gray),
	.rptr_gray (rptr_gray)
);

//--- fifo_async_tb.sv
`timescale 1ns/1ns

module fifo_async_tb;

	`include "fifo_defines.svh"

	localparam int          DEPTH = 1 << `FIFO_ADDR_W;
	localparam logic [31:0] SEED  = 32'h63d4_95d6;

	// DUT ports
	logic                 wr_clk;
	logic                 wr_rst;
	logic                 wr_en;
	logic                 full;
	logic                 rd_clk;
	logic                 rd_rst;
	logic                 rd_en;
	logic                 empty;
	fifo_data_pkg::data_t din;
	fifo_data_pkg::data_t dout;

	// Scoreboard
	int                   wr_count;
	int                   rd_count;
	int                   errors;
	int                   checks;
	int                   tests;
	int                   err_mark;
	int                   assert_fails;
	logic                 check_pending;
	int                   check_index;
	// Sequence scratch
	int                   start_count;
	int                   hold_count;
	int                   cycles;
	int                   empty_run;
	fifo_data_pkg::data_t hold_dout;
	logic [31:0]          wr_ctl_state;
	logic [31:0]          rd_ctl_state;

	fifo_async uut (
		.din    (din),
		.wr_en  (wr_en),
		.wr_clk (wr_clk),
		.wr_rst (wr_rst),
		.full   (full),
		.rd_en  (rd_en),
		.rd_clk (rd_clk),
		.rd_rst (rd_rst),
		.empty  (empty),
		.dout   (dout)
	);

	// --------------------------------------------------
	// Clocks, unrelated periods
	// --------------------------------------------------
	initial
	begin
		rd_clk = 1'b0;
		forever #2 rd_clk = ~rd_clk;
	end

	initial
	begin
		wr_clk = 1'b0;
		forever #3 wr_clk = ~wr_clk;
	end

	// --------------------------------------------------
	// Reference model and helpers
	// --------------------------------------------------

	// Standard 13/17/5 xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Word number k of the write stream, replayed from the seed
	function automatic fifo_data_pkg::data_t ref_word(input int k);
		logic [31:0] state;
		state = SEED;
		for (int i = 0; i <= k; i++)
		begin
			state = xorshift32(state);
		end
		return fifo_data_pkg::data_t'(state);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			$display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout at t=%0t, %s never happened", $time, what);
		$display("Some tests failed");
		$finish;
	endtask

	// Polls empty once per rd_clk cycle, just after the edge
	task automatic wait_for_empty(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (empty !== level && n < limit)
		begin
			@(posedge rd_clk);
			#1;
			n++;
		end
		if (empty !== level)
		begin
			abort_on_timeout(what);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d mismatches", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// --------------------------------------------------
	// Accepted-transfer monitors and compare
	// --------------------------------------------------

	// Count writes as the DUT takes them
	always @(posedge wr_clk)
	begin
		if (wr_rst)
			wr_count = 0;
		else if (wr_en && !full)
			wr_count = wr_count + 1;
	end

	// Registered mode checks one edge late, FWFT at the accepting edge
	always @(posedge rd_clk)
	begin
		if (rd_rst)
		begin
			rd_count      = 0;
			check_pending = 1'b0;
		end
		else
		begin
			if (check_pending)
			begin
				check_value("dout", ref_word(check_index), dout);
				check_pending = 1'b0;
			end
			if (rd_en && !empty)
			begin
				if (`FIFO_FWFT != 0)
				begin
					check_value("dout", ref_word(rd_count), dout);
				end
				else
				begin
					check_pending = 1'b1;
					check_index   = rd_count;
				end
				rd_count = rd_count + 1;
			end
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		wr_rst       = 1'b1;
		rd_rst       = 1'b1;
		wr_en        = 1'b0;
		rd_en        = 1'b0;
		din          = '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		err_mark     = 0;
		wr_ctl_state = SEED;
		rd_ctl_state = SEED;

		// Each reset held 3 cycles of its own clock
		fork
			begin
				repeat (3) @(posedge wr_clk);
				#1;
				wr_rst = 1'b0;
			end
			begin
				repeat (3) @(posedge rd_clk);
				#1;
				rd_rst = 1'b0;
			end
		join
		check_value("empty", 1, empty);
		check_value("full", 0, full);
		check_value("dout", 0, dout);
		report_test("reset state");

		// Single word through the FIFO
		@(posedge wr_clk);
		#1;
		wr_en = 1'b1;
		din   = ref_word(wr_count);
		@(posedge wr_clk);
		#1;
		wr_en = 1'b0;
		@(posedge rd_clk);
		#1;
		wait_for_empty(1'b0, 20, "empty falling after one write");
		rd_en = 1'b1;
		@(posedge rd_clk);
		#1;
		rd_en = 1'b0;
		@(posedge rd_clk);
		#1;
		check_value("rd_count", 1, rd_count);
		report_test("single transfer");

		// Fill with no reads, then push against full
		start_count = wr_count;
		cycles      = 0;
		@(posedge wr_clk);
		#1;
		wr_en = 1'b1;
		din   = ref_word(wr_count);
		while (!full && cycles < 4 * DEPTH)
		begin
			@(posedge wr_clk);
			#1;
			din = ref_word(wr_count);
			cycles++;
		end
		if (!full)
		begin
			abort_on_timeout("full rising during fill");
		end
		check_value("wr_count", start_count + DEPTH, wr_count);
		repeat (4)
		begin
			@(posedge wr_clk);
			#1;
		end
		check_value("wr_count", start_count + DEPTH, wr_count);
		check_value("full", 1, full);
		wr_en = 1'b0;
		report_test("fill to full");

		// Read everything back, then pull against empty
		start_count = rd_count;
		cycles      = 0;
		@(posedge rd_clk);
		#1;
		rd_en = 1'b1;
		while (!empty && cycles < 4 * DEPTH)
		begin
			@(posedge rd_clk);
			#1;
			cycles++;
		end
		if (!empty)
		begin
			abort_on_timeout("empty rising during drain");
		end
		check_value("rd_count", start_count + DEPTH, rd_count);
		@(posedge rd_clk);
		#1;
		hold_dout  = dout;
		hold_count = rd_count;
		repeat (4)
		begin
			@(posedge rd_clk);
			#1;
		end
		check_value("dout", hold_dout, dout);
		check_value("rd_count", hold_count, rd_count);
		check_value("empty", 1, empty);
		rd_en = 1'b0;
		report_test("drain in order");

		// Random strobes on both clocks at once
		fork
			begin
				repeat (300)
				begin
					@(posedge wr_clk);
					#1;
					wr_ctl_state = xorshift32(wr_ctl_state);
					wr_en        = |wr_ctl_state[1:0];
					din          = ref_word(wr_count);
				end
				@(posedge wr_clk);
				#1;
				wr_en = 1'b0;
			end
			begin
				repeat (450)
				begin
					@(posedge rd_clk);
					#1;
					rd_ctl_state = xorshift32(rd_ctl_state);
					rd_en        = rd_ctl_state[7];
				end
			end
		join
		cycles    = 0;
		empty_run = 0;
		@(posedge rd_clk);
		#1;
		rd_en = 1'b1;
		// Empty has to stay high longer than a write pointer takes to cross
		while (empty_run < 4 && cycles < 8 * DEPTH)
		begin
			@(posedge rd_clk);
			#1;
			if (empty)
				empty_run++;
			else
				empty_run = 0;
			cycles++;
		end
		if (empty_run < 4)
		begin
			abort_on_timeout("final drain after random traffic");
		end
		rd_en = 1'b0;
		@(posedge rd_clk);
		#1;
		check_value("rd_count", wr_count, rd_count);
		report_test("random concurrent traffic");

		assert_fails = uut.u_asserts.fail_count;
		$display("tests=%0d checks=%0d errors=%0d assert_fails=%0d writes=%0d reads=%0d",
			tests, checks, errors, assert_fails, wr_count, rd_count);
		if (errors == 0 && assert_fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+.
fifo_ptr_pkg.sv
fifo_data_pkg.sv
fifo_mem_if.sv
fifo_dual_port_ram.sv
fifo_ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
fifo_async.sv
fifo_async_asserts.sv
fifo_async_tb.sv
